// File: icache_top.f
cache_cfg_pkg.sv
cache_bus_pkg.sv
line_regfile.sv
replacement_policy.sv
refill_counter.sv
cache_fsm.sv
cache_ways.sv
icache_top.sv
tb_icache_top.sv

// File: tb_icache_top.sv
module tb_icache_top;

   import cache_cfg_pkg::*;
   import cache_bus_pkg::*;

   localparam int                N_WAYS     = 4;
   localparam int                NLINES_W   = 2;
   localparam int                WORDS_W    = 2;
   localparam rep_policy_e       REP_POLICY = REP_PLRU_TREE;
   localparam logic [DATA_W-1:0] PATTERN    = 32'hC3A5_5A3C;  // memory word = addr ^ this
   localparam int                N_RANDOM   = 70;
   // 80 requests, each at most a 4-word refill of 4 cycles per word plus overhead
   localparam int                MAX_CYCLES = 80 * (4 * 4 + 4) * 2;

   logic clk    = 1'b0;
   logic arst_n = 1'b0;

   fe_req_t  fe_req  = '0;
   fe_rsp_t  fe_rsp;
   logic     busy;
   mem_req_t mem_req;
   mem_rsp_t mem_rsp = '0;

   logic [ADDR_W-1:0]  pend_addr = '0;   // address of the request in flight
   logic               hit_exp   = 1'b0; // request must hit
   logic               seen_req  = 1'b0; // first request has been driven
   logic [WORDS_W-1:0] exp_off;          // word the refill should fetch now
   logic [ADDR_W-1:0]  exp_addr;
   logic [1:0]         mem_wait;         // idle cycles before the next memory word
   logic [15:0]        addr_lfsr = 16'd99;
   logic [15:0]        mem_lfsr  = 16'd99;
   int                 cycle_cnt = 0;

   int reset_errs  = 0;
   int hit_errs    = 0;
   int refill_errs = 0;
   int data_errs   = 0;

   always #20 clk = ~clk;

   icache_top #(
      .N_WAYS     (N_WAYS),
      .NLINES_W   (NLINES_W),
      .WORDS_W    (WORDS_W),
      .REP_POLICY (REP_POLICY)
   ) icache_top_inst (
      .clk_i     (clk),
      .arst_n_i  (arst_n),
      .fe_req_i  (fe_req),
      .fe_rsp_o  (fe_rsp),
      .busy_o    (busy),
      .mem_req_o (mem_req),
      .mem_rsp_i (mem_rsp)
   );

   // fibonacci lfsr, taps 16 14 13 11
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   // one step per bit, bits collected msb first
   function automatic logic [15:0] take_bits(inout logic [15:0] s, input int n);
      logic [15:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         s = lfsr_step(s);
         v = {v[14:0], s[0]};
      end
      return v;
   endfunction

   function automatic void show_error_counts();
      $display("errors: reset %0d  hit %0d  refill %0d  data %0d",
               reset_errs, hit_errs, refill_errs, data_errs);
   endfunction

   // call on a rising edge, returns on the edge where busy is seen low
   task automatic issue_read(input logic [ADDR_W-1:0] addr, input logic must_hit);
      fe_req    <= '{valid: 1'b1, addr: addr};
      pend_addr <= addr;
      hit_exp   <= must_hit;
      seen_req  <= 1'b1;
      @(posedge clk);
      fe_req.valid <= 1'b0;  // one-cycle strobe
      do begin
         @(posedge clk);
      end while (busy);
   endtask

   // backing memory, 1 to 3 cycles per word
   always @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         mem_rsp  <= '0;
         mem_wait <= '0;
      end else begin
         mem_rsp.valid <= 1'b0;
         if (mem_req.req && !mem_rsp.valid) begin
            if (mem_wait == '0) begin
               mem_rsp  <= '{valid: 1'b1, data: DATA_W'(mem_req.addr) ^ PATTERN};
               mem_wait <= 2'(take_bits(mem_lfsr, 2) % 3);
            end else begin
               mem_wait <= mem_wait - 1'b1;
            end
         end
      end
   end

   // expected refill word, from the line base up by one per returned word
   always @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         exp_off <= '0;
      end else if (!mem_req.req) begin
         exp_off <= '0;
      end else if (mem_rsp.valid) begin
         exp_off <= exp_off + 1'b1;
      end
   end

   assign exp_addr = {pend_addr[ADDR_W-1:WORDS_W], exp_off};

   // quiet outputs between reset and the first request
   a_idle_after_reset : assert property (@(posedge clk) disable iff (!arst_n)
      !seen_req |-> !busy && !fe_rsp.valid && !mem_req.req)
      else begin
         reset_errs++;
         $display("** Error: {busy_o, fe_rsp_o.valid, mem_req_o.req} = %h, expected 0",
                  $sampled({busy, fe_rsp.valid, mem_req.req}));
      end

   // lookup cycle, then the strobe, no refill in between
   a_hit_latency : assert property (@(posedge clk) disable iff (!arst_n)
      fe_req.valid && hit_exp |=> !fe_rsp.valid && !mem_req.req
                                  ##1 fe_rsp.valid && !mem_req.req)
      else begin
         hit_errs++;
         $display("expected hit on address %h got no response one cycle after lookup",
                  $sampled(pend_addr));
      end

   a_refill_addr : assert property (@(posedge clk) disable iff (!arst_n)
      mem_req.req |-> mem_req.addr == exp_addr)
      else begin
         refill_errs++;
         $display("** Error: mem_req_o.addr = %h, expected %h",
                  $sampled(mem_req.addr), $sampled(exp_addr));
      end

   a_refill_continue : assert property (@(posedge clk) disable iff (!arst_n)
      mem_req.req && mem_rsp.valid && exp_off != '1 |=> mem_req.req)
      else begin
         refill_errs++;
         $display("refill of line %h ended before its last word",
                  $sampled(pend_addr[ADDR_W-1:WORDS_W]));
      end

   a_refill_stop : assert property (@(posedge clk) disable iff (!arst_n)
      mem_req.req && mem_rsp.valid && exp_off == '1 |=> !mem_req.req)
      else begin
         refill_errs++;
         $display("memory request still high after the last word of the line");
      end

   a_rsp_data : assert property (@(posedge clk) disable iff (!arst_n)
      fe_rsp.valid |-> fe_rsp.data == (DATA_W'(pend_addr) ^ PATTERN))
      else begin
         data_errs++;
         $display("** Error: fe_rsp_o.data = %h, expected %h",
                  $sampled(fe_rsp.data), DATA_W'($sampled(pend_addr)) ^ PATTERN);
      end

   // every request ends with a strobe
   a_rsp_at_end : assert property (@(posedge clk) disable iff (!arst_n)
      $fell(busy) |-> fe_rsp.valid)
      else begin
         data_errs++;
         $display("busy_o fell without a response strobe for address %h",
                  $sampled(pend_addr));
      end

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= MAX_CYCLES) begin
         $display("timeout, run did not finish within %0d cycles", MAX_CYCLES);
         show_error_counts();
         $display("TEST FAILED");
         $finish;
      end
   end

   initial begin : stimulus
      logic [ADDR_W-1:0] addr;
      logic [ADDR_W-1:0] last_addr;
      logic [1:0]        pick;
      repeat (10) @(posedge clk);
      arst_n <= 1'b1;
      @(posedge clk);
      // same address twice, miss then hit
      issue_read(16'h0123, 1'b0);
      issue_read(16'h0123, 1'b1);
      // five tags on line 1, first tag touched again before the fifth
      issue_read(16'h1004, 1'b0);
      issue_read(16'h2005, 1'b0);
      issue_read(16'h3006, 1'b0);
      issue_read(16'h4007, 1'b0);
      issue_read(16'h1005, 1'b1);
      issue_read(16'h5004, 1'b0);
      issue_read(16'h1006, 1'b1);  // must have survived the fifth refill
      last_addr = 16'h1006;
      // 8 tags over 4 lines, so hits and evictions mix
      for (int i = 0; i < N_RANDOM; i++) begin
         pick = 2'(take_bits(addr_lfsr, 2));
         if (pick == 2'd0) begin
            addr = last_addr;  // forced repeat
         end else begin
            addr = 16'h0A00 | take_bits(addr_lfsr, 7);
         end
         issue_read(addr, addr == last_addr);
         last_addr = addr;
      end
      repeat (4) @(posedge clk);  // drain the last checks
      show_error_counts();
      if (reset_errs + hit_errs + refill_errs + data_errs == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

// File: icache_top.sv
module icache_top #(
   parameter int                         N_WAYS     = 4,
   parameter int                         NLINES_W   = 2,
   parameter int                         WORDS_W    = 2,
   parameter cache_cfg_pkg::rep_policy_e REP_POLICY = cache_cfg_pkg::REP_PLRU_TREE
) (
   input  logic                     clk_i,
   input  logic                     arst_n_i,
   input  cache_bus_pkg::fe_req_t   fe_req_i,
   output cache_bus_pkg::fe_rsp_t   fe_rsp_o,
   output logic                     busy_o,
   output cache_bus_pkg::mem_req_t  mem_req_o,
   input  cache_bus_pkg::mem_rsp_t  mem_rsp_i
);

   import cache_cfg_pkg::*;

   logic [ADDR_W-1:0]  req_addr;      // latched by the fsm
   logic               hit;
   logic [N_WAYS-1:0]  way_hit;
   logic [N_WAYS-1:0]  victim_oh;
   logic [DATA_W-1:0]  rdata;
   logic [WORDS_W-1:0] word_off;
   logic               last_word;
   logic               refill_start;
   logic               word_ack;
   logic               tag_we;
   logic               data_we;
   logic               policy_update;
   logic               refill_req;

   // line base of the request plus the word being fetched
   assign mem_req_o = '{req: refill_req, addr: {req_addr[ADDR_W-1:WORDS_W], word_off}};

   cache_fsm fsm (
      .clk_i           (clk_i),
      .arst_n_i        (arst_n_i),
      .fe_req_i        (fe_req_i),
      .hit_i           (hit),
      .rdata_i         (rdata),
      .mem_rsp_i       (mem_rsp_i),
      .last_word_i     (last_word),
      .addr_o          (req_addr),
      .busy_o          (busy_o),
      .fe_rsp_o        (fe_rsp_o),
      .mem_req_o       (refill_req),
      .refill_start_o  (refill_start),
      .word_ack_o      (word_ack),
      .tag_we_o        (tag_we),
      .data_we_o       (data_we),
      .policy_update_o (policy_update)
   );

   refill_counter #(
      .WORDS_W (WORDS_W)
   ) word_cnt (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .start_i     (refill_start),
      .word_ack_i  (word_ack),
      .offset_o    (word_off),
      .last_word_o (last_word)
   );

   cache_ways #(
      .N_WAYS   (N_WAYS),
      .NLINES_W (NLINES_W),
      .WORDS_W  (WORDS_W)
   ) ways (
      .clk_i      (clk_i),
      .arst_n_i   (arst_n_i),
      .addr_i     (req_addr),
      .tag_we_i   (tag_we),
      .data_we_i  (data_we),
      .way_sel_i  (victim_oh),
      .word_off_i (word_off),
      .wdata_i    (mem_rsp_i.data),
      .way_hit_o  (way_hit),
      .hit_o      (hit),
      .rdata_o    (rdata)
   );

   replacement_policy #(
      .N_WAYS     (N_WAYS),
      .NLINES_W   (NLINES_W),
      .REP_POLICY (REP_POLICY)
   ) policy (
      .clk_i            (clk_i),
      .arst_n_i         (arst_n_i),
      .update_i         (policy_update),
      .way_hit_i        (way_hit),          // refilled victim hits in ST_UPDATE too
      .line_addr_i      (req_addr[WORDS_W +: NLINES_W]),
      .way_select_o     (victim_oh),
      .way_select_bin_o ()                  // binary form not needed here
   );

endmodule

// File: cache_ways.sv
module cache_ways #(
   parameter int N_WAYS   = 4,
   parameter int NLINES_W = 2,
   parameter int WORDS_W  = 2
) (
   input  logic                             clk_i,
   input  logic                             arst_n_i,
   input  logic [cache_cfg_pkg::ADDR_W-1:0] addr_i,
   input  logic                             tag_we_i,
   input  logic                             data_we_i,
   input  logic [N_WAYS-1:0]                way_sel_i,   // refill way, one-hot
   input  logic [WORDS_W-1:0]               word_off_i,  // refill word in line
   input  logic [cache_cfg_pkg::DATA_W-1:0] wdata_i,
   output logic [N_WAYS-1:0]                way_hit_o,
   output logic                             hit_o,
   output logic [cache_cfg_pkg::DATA_W-1:0] rdata_o
);

   import cache_cfg_pkg::*;

   localparam int TAG_W  = ADDR_W - NLINES_W - WORDS_W;
   localparam int DEPTH  = 2**(NLINES_W + WORDS_W);  // words per way

   typedef struct packed {
      logic             valid;
      logic [TAG_W-1:0] tag;
   } tag_entry_t;

   logic [TAG_W-1:0]    req_tag;
   logic [NLINES_W-1:0] req_line;
   logic [WORDS_W-1:0]  req_word;
   tag_entry_t          tag_wdata;
   logic [DATA_W-1:0]   way_word [N_WAYS];  // addressed word of each way

   // address split tag | line | word
   assign req_tag   = addr_i[ADDR_W-1 -: TAG_W];
   assign req_line  = addr_i[WORDS_W +: NLINES_W];
   assign req_word  = addr_i[WORDS_W-1:0];
   assign tag_wdata = '{valid: 1'b1, tag: req_tag};

   for (genvar w = 0; w < N_WAYS; w++) begin : g_way
      tag_entry_t        entry;
      logic [DATA_W-1:0] data_q [DEPTH];

      line_regfile #(
         .NLINES_W (NLINES_W),
         .ENTRY_T  (tag_entry_t)
      ) tag_rf (
         .clk_i    (clk_i),
         .arst_n_i (arst_n_i),
         .we_i     (tag_we_i && way_sel_i[w]),
         .addr_i   (req_line),
         .wdata_i  (tag_wdata),
         .rdata_o  (entry)
      );

      always_ff @(posedge clk_i) begin
         if (data_we_i && way_sel_i[w]) begin
            data_q[{req_line, word_off_i}] <= wdata_i;
         end
      end

      assign way_hit_o[w] = entry.valid && (entry.tag == req_tag);
      assign way_word[w]  = data_q[{req_line, req_word}];
   end

   assign hit_o = |way_hit_o;

   // and-or select, zero on a miss
   always_comb begin
      rdata_o = '0;
      for (int w = 0; w < N_WAYS; w++) begin
         if (way_hit_o[w]) begin
            rdata_o = rdata_o | way_word[w];
         end
      end
   end

   // refill must never load a tag that another way already holds
   a_hit_onehot0 : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      $onehot0(way_hit_o))
      else $error("multiple ways hit: %h", way_hit_o);

endmodule

// File: cache_fsm.sv
module cache_fsm (
   input  logic                             clk_i,
   input  logic                             arst_n_i,
   input  cache_bus_pkg::fe_req_t           fe_req_i,
   input  logic                             hit_i,
   input  logic [cache_cfg_pkg::DATA_W-1:0] rdata_i,
   input  cache_bus_pkg::mem_rsp_t          mem_rsp_i,
   input  logic                             last_word_i,
   output logic [cache_cfg_pkg::ADDR_W-1:0] addr_o,          // latched request address
   output logic                             busy_o,
   output cache_bus_pkg::fe_rsp_t           fe_rsp_o,
   output logic                             mem_req_o,       // refill in progress
   output logic                             refill_start_o,
   output logic                             word_ack_o,
   output logic                             tag_we_o,
   output logic                             data_we_o,
   output logic                             policy_update_o
);

   import cache_cfg_pkg::*;

   fsm_state_e        state_q, state_d;
   logic [ADDR_W-1:0] addr_q;
   logic              rsp_valid_q;
   logic [DATA_W-1:0] rsp_data_q;
   logic              lookup_hit;  // answer goes out at the next edge

   assign lookup_hit = (state_q == ST_LOOKUP) && hit_i;

   always_comb begin
      state_d         = state_q;
      refill_start_o  = 1'b0;
      word_ack_o      = 1'b0;
      data_we_o       = 1'b0;
      tag_we_o        = 1'b0;
      policy_update_o = 1'b0;
      case (state_q)
         ST_IDLE: begin
            if (fe_req_i.valid) begin
               state_d = ST_LOOKUP;
            end
         end
         ST_LOOKUP: begin
            if (hit_i) begin
               policy_update_o = 1'b1;  // used way becomes most recent
               state_d         = ST_IDLE;
            end else begin
               refill_start_o = 1'b1;   // clear word counter
               state_d        = ST_REFILL;
            end
         end
         ST_REFILL: begin
            if (mem_rsp_i.valid) begin
               word_ack_o = 1'b1;
               data_we_o  = 1'b1;       // word into victim way
               if (last_word_i) begin
                  tag_we_o = 1'b1;      // line complete, mark it valid
                  state_d  = ST_UPDATE;
               end
            end
         end
         ST_UPDATE: begin
            policy_update_o = 1'b1;     // refilled way counts as used
            state_d         = ST_LOOKUP;
         end
         default: state_d = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q     <= ST_IDLE;
         rsp_valid_q <= 1'b0;
      end else begin
         state_q     <= state_d;
         rsp_valid_q <= lookup_hit;  // one-cycle strobe
      end
   end

   always_ff @(posedge clk_i) begin
      if ((state_q == ST_IDLE) && fe_req_i.valid) begin
         addr_q <= fe_req_i.addr;
      end
      if (lookup_hit) begin
         rsp_data_q <= rdata_i;
      end
   end

   assign addr_o    = addr_q;
   assign busy_o    = (state_q != ST_IDLE);
   assign mem_req_o = (state_q == ST_REFILL);
   assign fe_rsp_o  = '{valid: rsp_valid_q, data: rsp_data_q};

   // requester has to wait for busy to drop
   a_no_req_while_busy : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      busy_o |-> !fe_req_i.valid)
      else $error("request strobe while busy");

endmodule

// File: refill_counter.sv
module refill_counter #(
   parameter int WORDS_W = 2
) (
   input  logic               clk_i,
   input  logic               arst_n_i,
   input  logic               start_i,     // new refill begins
   input  logic               word_ack_i,  // one word came back
   output logic [WORDS_W-1:0] offset_o,    // word in line being fetched
   output logic               last_word_o
);

   logic [WORDS_W-1:0] offset_q;
   logic               done_q;  // whole line received, no start since

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         offset_q <= '0;
         done_q   <= 1'b0;
      end else if (start_i) begin
         offset_q <= '0;  // refill always starts at the line base
         done_q   <= 1'b0;
      end else if (word_ack_i) begin
         offset_q <= offset_q + 1'b1;  // wraps to zero after the last word
         done_q   <= last_word_o;
      end
   end

   assign offset_o    = offset_q;
   assign last_word_o = &offset_q;  // offset at its maximum

   // memory must not return more words than one line
   a_no_ack_after_last : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      done_q |-> !word_ack_i)
      else $error("word ack after last word of line");

endmodule

// File: replacement_policy.sv
module replacement_policy #(
   parameter int                         N_WAYS     = 4,
   parameter int                         NLINES_W   = 2,
   parameter cache_cfg_pkg::rep_policy_e REP_POLICY = cache_cfg_pkg::REP_PLRU_TREE
) (
   input  logic                      clk_i,
   input  logic                      arst_n_i,
   input  logic                      update_i,       // write new state for this line
   input  logic [N_WAYS-1:0]         way_hit_i,      // way just used, one-hot
   input  logic [NLINES_W-1:0]       line_addr_i,
   output logic [N_WAYS-1:0]         way_select_o,   // victim, one-hot
   output logic [$clog2(N_WAYS)-1:0] way_select_bin_o
);

   import cache_cfg_pkg::*;

   localparam int NWAYS_W = $clog2(N_WAYS);

   logic [N_WAYS-1:0] sel_oh;  // victim from whichever scheme is built

   if (REP_POLICY == REP_LRU) begin : g_lru
      typedef logic [N_WAYS-1:0][NWAYS_W-1:0] rank_t;

      rank_t              rank_q, rank_d;
      rank_t              rank;      // stored ranks, or defaults on a fresh line
      logic [NWAYS_W-1:0] hit_rank;  // old rank of the used way

      always_comb begin
         hit_rank = '0;
         for (int w = 0; w < N_WAYS; w++) begin
            // all-zero means never written, start from rank = way index
            rank[w] = (|rank_q) ? rank_q[w] : NWAYS_W'(w);
         end
         for (int w = 0; w < N_WAYS; w++) begin
            if (way_hit_i[w]) begin
               hit_rank = rank[w];
            end
         end
         for (int w = 0; w < N_WAYS; w++) begin
            if (way_hit_i[w]) begin
               rank_d[w] = '1;                 // used way goes to the top
            end else if (rank[w] > hit_rank) begin
               rank_d[w] = rank[w] - 1'b1;     // ranks above it slide down
            end else begin
               rank_d[w] = rank[w];
            end
            sel_oh[w] = (rank[w] == '0);       // rank zero is the victim
         end
      end

      line_regfile #(
         .NLINES_W (NLINES_W),
         .ENTRY_T  (rank_t)
      ) state_rf (
         .clk_i    (clk_i),
         .arst_n_i (arst_n_i),
         .we_i     (update_i),
         .addr_i   (line_addr_i),
         .wdata_i  (rank_d),
         .rdata_o  (rank_q)
      );
   end else if (REP_POLICY == REP_PLRU_MRU) begin : g_mru
      logic [N_WAYS-1:0] mru_q, mru_d;
      logic [N_WAYS-1:0] mru_set;  // bits after marking the used way

      assign mru_set = mru_q | way_hit_i;
      // saturated set restarts with only the used way marked
      assign mru_d   = (&mru_set) ? way_hit_i : mru_set;
      // lowest clear bit, never empty since the state is never all ones
      assign sel_oh  = ~mru_q & (mru_q + 1'b1);

      line_regfile #(
         .NLINES_W (NLINES_W),
         .ENTRY_T  (logic [N_WAYS-1:0])
      ) state_rf (
         .clk_i    (clk_i),
         .arst_n_i (arst_n_i),
         .we_i     (update_i),
         .addr_i   (line_addr_i),
         .wdata_i  (mru_d),
         .rdata_o  (mru_q)
      );
   end else begin : g_tree
      // node k has children 2k and 2k+1, leaves N_WAYS.. map to the ways
      typedef logic [N_WAYS-1:1] tree_t;

      tree_t tree_q, tree_d;

      // walk from the root, 0 goes left and 1 goes right
      always_comb begin
         int unsigned n;
         n = 1;
         for (int l = 0; l < NWAYS_W; l++) begin
            n = 2 * n + tree_q[n];
         end
         sel_oh = '0;
         sel_oh[n - N_WAYS] = 1'b1;
      end

      // climb from the used leaf, every node on the way points to the other side
      always_comb begin
         int unsigned c;
         c      = 0;
         tree_d = tree_q;
         for (int w = 0; w < N_WAYS; w++) begin
            if (way_hit_i[w]) begin
               c = w + N_WAYS;
               for (int l = 0; l < NWAYS_W; l++) begin
                  tree_d[c >> 1] = ~c[0];  // came from left, point right
                  c = c >> 1;
               end
            end
         end
      end

      line_regfile #(
         .NLINES_W (NLINES_W),
         .ENTRY_T  (tree_t)
      ) state_rf (
         .clk_i    (clk_i),
         .arst_n_i (arst_n_i),
         .we_i     (update_i),
         .addr_i   (line_addr_i),
         .wdata_i  (tree_d),
         .rdata_o  (tree_q)
      );
   end

   assign way_select_o = sel_oh;

   // binary index of the victim
   always_comb begin
      way_select_bin_o = '0;
      for (int w = 0; w < N_WAYS; w++) begin
         if (sel_oh[w]) begin
            way_select_bin_o = NWAYS_W'(w);
         end
      end
   end

   // stored state must keep naming exactly one victim after any update history
   a_victim_onehot : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      $onehot(way_select_o))
      else $error("victim select not one-hot: %h", way_select_o);

endmodule

// File: line_regfile.sv
module line_regfile #(
   parameter int  NLINES_W = 2,
   parameter type ENTRY_T  = logic
) (
   input  logic                clk_i,
   input  logic                arst_n_i,
   input  logic                we_i,
   input  logic [NLINES_W-1:0] addr_i,
   input  ENTRY_T              wdata_i,
   output ENTRY_T              rdata_o
);

   localparam int NLINES = 2**NLINES_W;

   ENTRY_T mem_q [NLINES];  // one entry per cache line

   // single port, write on the edge
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         for (int i = 0; i < NLINES; i++) begin
            mem_q[i] <= '0;  // invalid tags, fresh policy state
         end
      end else if (we_i) begin
         mem_q[addr_i] <= wdata_i;
      end
   end

   // read is combinational, same address as the write
   assign rdata_o = mem_q[addr_i];

endmodule

// File: cache_bus_pkg.sv
package cache_bus_pkg;

   // front side, requester to cache
   typedef struct packed {
      logic                             valid;  // one-cycle read strobe
      logic [cache_cfg_pkg::ADDR_W-1:0] addr;   // word address
   } fe_req_t;

   // front side, cache to requester
   typedef struct packed {
      logic                             valid;  // one-cycle data strobe
      logic [cache_cfg_pkg::DATA_W-1:0] data;
   } fe_rsp_t;

   // back side, cache to memory
   typedef struct packed {
      logic                             req;   // level, held for the whole refill
      logic [cache_cfg_pkg::ADDR_W-1:0] addr;  // next word to fetch
   } mem_req_t;

   // back side, memory to cache
   typedef struct packed {
      logic                             valid;  // one strobe per word
      logic [cache_cfg_pkg::DATA_W-1:0] data;
   } mem_rsp_t;

endpackage

// File: cache_cfg_pkg.sv
package cache_cfg_pkg;

   // word address and data widths of both buses
   localparam int ADDR_W = 16;  // word address, not byte address
   localparam int DATA_W = 32;

   // victim selection schemes of replacement_policy
   typedef enum logic [1:0] {
      REP_LRU       = 2'd0,  // true lru, one rank per way
      REP_PLRU_MRU  = 2'd1,  // one mru bit per way
      REP_PLRU_TREE = 2'd2   // binary tree of N_WAYS-1 node bits
   } rep_policy_e;

   // controller states
   typedef enum logic [1:0] {
      ST_IDLE   = 2'd0,  // waiting for a request strobe
      ST_LOOKUP = 2'd1,  // tag compare on the latched address
      ST_REFILL = 2'd2,  // line fetch from backing memory
      ST_UPDATE = 2'd3   // victim becomes most recent, then lookup again
   } fsm_state_e;

endpackage
